/* design/lsq_pkg.sv */
// Shared widths, types and the CDB wakeup helper for the load/store queue.
// While an operand is not ready its low PRF_TAG_W bits hold the producer tag.
// Memory tag zero means no tag on both response and data return.

package lsq_pkg;

	localparam int DATA_W    = 64;
	localparam int PRF_TAG_W = 6;
	localparam int ROB_IDX_W = 5;
	localparam int MEM_TAG_W = 4;

	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [PRF_TAG_W-1:0] prf_tag_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [MEM_TAG_W-1:0] mem_tag_t;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE,
		MEM_LDA                     // Address only, no memory access
	} mem_op_e;

	typedef enum logic [1:0] {
		BUS_NONE,
		BUS_LOAD,
		BUS_STORE
	} bus_cmd_e;

	typedef struct packed {
		logic     valid;
		prf_tag_t tag;
		data_t    data;
	} cdb_t;

	typedef struct packed {
		logic     valid;
		mem_op_e  op;
		data_t    opa;                // Base, always data
		data_t    opb;                // Offset or tag
		logic     opb_ready;
		data_t    rega;               // Store data or tag
		logic     rega_ready;
		rob_idx_t rob_idx;
		prf_tag_t dest_tag;
	} dispatch_t;

	typedef struct packed {
		logic     valid;
		prf_tag_t dest_tag;
		rob_idx_t rob_idx;
		data_t    data;
	} result_t;

	typedef struct packed {
		bus_cmd_e cmd;
		data_t    addr;
		data_t    data;
	} mem_req_t;

	// Capture CDB data into any operand still waiting on the broadcast tag
	function automatic dispatch_t wakeup(dispatch_t d, cdb_t c);
		dispatch_t w;
		w = d;
		if (c.valid && !d.opb_ready && c.tag == d.opb[PRF_TAG_W-1:0]) begin
			w.opb       = c.data;
			w.opb_ready = 1'b1;
		end
		if (c.valid && !d.rega_ready && c.tag == d.rega[PRF_TAG_W-1:0]) begin
			w.rega       = c.data;
			w.rega_ready = 1'b1;
		end
		return w;
	endfunction

endpackage

/* design/lsq_dispatch.sv */
// Dispatch stage. One instruction per cycle, captured for one cycle.
// Load-address results leave combinationally and are registered by the result bus.
// A load-address instruction expects opb ready at dispatch or on the CDB that cycle.

`timescale 1ns/100ps

module lsq_dispatch import lsq_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      mispredict,
	input  dispatch_t dispatch,
	input  cdb_t      cdb,
	output dispatch_t dispatch_q,
	output result_t   lda_result
);

	dispatch_t woken;
	logic      is_lda;
	logic      is_mem;

	assign woken  = wakeup(dispatch, cdb);        // Wakeup at dispatch
	assign is_lda = woken.valid && woken.op == MEM_LDA;
	assign is_mem = woken.valid && (woken.op == MEM_LOAD || woken.op == MEM_STORE);

	////////////////////////////////////////////////////////////
	// Load-address, base plus offset
	////////////////////////////////////////////////////////////

	always_comb begin
		lda_result.valid    = is_lda && !mispredict;   // Wrong-path LDA dropped
		lda_result.dest_tag = woken.dest_tag;
		lda_result.rob_idx  = woken.rob_idx;
		lda_result.data     = woken.opa + woken.opb;
	end

	////////////////////////////////////////////////////////////
	// Dispatch register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			dispatch_q.valid <= 1'b0;
		end else begin
			dispatch_q       <= woken;
			// Only loads and stores go on to the queues
			dispatch_q.valid <= is_mem && !mispredict;
		end
	end

endmodule

/* design/load_queue.sv */
// Load queue. Entries are allocated at the lowest free index.
// Each load counts the stores ahead of it and waits until that count is zero,
// so a load never passes an older store. LQ_SIZE and SQ_SIZE powers of two, 2 or more.

`timescale 1ns/100ps

module load_queue import lsq_pkg::*; #(
	parameter int LQ_SIZE = 4,
	parameter int SQ_SIZE = 4
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       mispredict,
	input  dispatch_t                  dispatch_q,
	input  cdb_t                       cdb,
	input  logic [$clog2(SQ_SIZE):0]   sq_count,
	input  logic                       store_done,
	output logic                       issue_valid,
	output logic [$clog2(LQ_SIZE)-1:0] issue_idx,
	output data_t                      issue_addr,
	input  logic                       issued,
	input  logic [$clog2(LQ_SIZE)-1:0] issued_idx,
	input  logic                       fill_valid,
	input  logic [$clog2(LQ_SIZE)-1:0] fill_idx,
	input  data_t                      fill_data,
	output result_t                    load_result,
	input  logic                       load_grant,
	output logic [$clog2(LQ_SIZE):0]   lq_free
);

	localparam int IDX_W = $clog2(LQ_SIZE);
	localparam int CNT_W = $clog2(SQ_SIZE) + 1;

	dispatch_t          ent [LQ_SIZE];
	data_t              ent_data [LQ_SIZE];
	logic [CNT_W-1:0]   older [LQ_SIZE];          // Stores still ahead of this load
	logic [LQ_SIZE-1:0] ent_valid;
	logic [LQ_SIZE-1:0] requested;
	logic [LQ_SIZE-1:0] filled;

	dispatch_t          incoming;
	logic               alloc_en;
	logic               write_en;
	logic [IDX_W-1:0]   alloc_idx;
	logic [IDX_W-1:0]   out_idx;
	logic [CNT_W-1:0]   older_init;

	assign incoming   = wakeup(dispatch_q, cdb);
	assign write_en   = dispatch_q.valid && dispatch_q.op == MEM_LOAD && alloc_en;
	// A store leaving on this edge is no longer ahead of the new load
	assign older_init = (store_done && sq_count != '0) ? sq_count - 1'b1 : sq_count;
	assign issue_addr = ent[issue_idx].opa + ent[issue_idx].opb;

	// Scan from the top so the lowest index wins
	always_comb begin
		alloc_en          = 1'b0;
		alloc_idx         = '0;
		issue_valid       = 1'b0;
		issue_idx         = '0;
		load_result.valid = 1'b0;
		out_idx           = '0;
		lq_free           = (IDX_W+1)'(LQ_SIZE);
		for (int i = LQ_SIZE - 1; i >= 0; i--) begin
			if (!ent_valid[i]) begin
				alloc_en  = 1'b1;
				alloc_idx = IDX_W'(i);
			end else begin
				lq_free = lq_free - 1'b1;
			end
			if (ent_valid[i] && ent[i].opb_ready && !requested[i] && older[i] == '0) begin
				issue_valid = 1'b1;
				issue_idx   = IDX_W'(i);
			end
			if (ent_valid[i] && filled[i]) begin
				load_result.valid = !mispredict;
				out_idx           = IDX_W'(i);
			end
		end
		load_result.dest_tag = ent[out_idx].dest_tag;
		load_result.rob_idx  = ent[out_idx].rob_idx;
		load_result.data     = ent_data[out_idx];
	end

	////////////////////////////////////////////////////////////
	// Entry state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			ent_valid <= '0;
			requested <= '0;
			filled    <= '0;
		end else begin
			if (write_en) begin
				ent_valid[alloc_idx] <= 1'b1;
				requested[alloc_idx] <= 1'b0;
				filled[alloc_idx]    <= 1'b0;
			end
			if (issued)
				requested[issued_idx] <= 1'b1;
			if (fill_valid)
				filled[fill_idx] <= 1'b1;
			if (load_grant)
				ent_valid[out_idx] <= 1'b0;   // Released once on the result bus
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < LQ_SIZE; i++) begin
			if (write_en && alloc_idx == IDX_W'(i)) begin
				ent[i]   <= incoming;
				older[i] <= older_init;
			end else begin
				ent[i] <= wakeup(ent[i], cdb);
				if (store_done && older[i] != '0)
					older[i] <= older[i] - 1'b1;
			end
		end
		if (fill_valid)
			ent_data[fill_idx] <= fill_data;
	end

endmodule

/* design/store_queue.sv */
// Store queue, a circular buffer kept in program order.
// Only the head may write memory, and only when the ROB head has reached it.
// A store pushed while the queue is full is lost, dispatch must respect lsq_full.

`timescale 1ns/100ps

module store_queue import lsq_pkg::*; #(
	parameter int SQ_SIZE = 4
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     mispredict,
	input  dispatch_t                dispatch_q,
	input  cdb_t                     cdb,
	input  rob_idx_t                 rob_head,
	output logic                     head_ready,
	output data_t                    head_addr,
	output data_t                    head_data,
	input  logic                     store_done,
	output logic [$clog2(SQ_SIZE):0] sq_count,
	output logic [$clog2(SQ_SIZE):0] sq_free
);

	localparam int IDX_W = $clog2(SQ_SIZE);

	dispatch_t          ent [SQ_SIZE];
	logic [SQ_SIZE-1:0] ent_valid;
	logic [IDX_W-1:0]   head;
	logic [IDX_W-1:0]   tail;
	logic [IDX_W:0]     count;

	dispatch_t          incoming;
	dispatch_t          head_ent;
	logic               push;

	assign incoming = wakeup(dispatch_q, cdb);
	assign push     = dispatch_q.valid && dispatch_q.op == MEM_STORE
		&& count != (IDX_W+1)'(SQ_SIZE);
	assign head_ent = ent[head];

	////////////////////////////////////////////////////////////
	// Head store offered to memory
	////////////////////////////////////////////////////////////

	assign head_ready = ent_valid[head] && head_ent.opb_ready && head_ent.rega_ready
		&& head_ent.rob_idx == rob_head;           // Commits in ROB order
	assign head_addr  = head_ent.opa + head_ent.opb;
	assign head_data  = head_ent.rega;

	assign sq_count = count;
	assign sq_free  = (IDX_W+1)'(SQ_SIZE) - count;

	// Pointers and occupancy
	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			ent_valid <= '0;
			head      <= '0;
			tail      <= '0;
			count     <= '0;
		end else begin
			if (push) begin
				ent_valid[tail] <= 1'b1;
				tail            <= tail + 1'b1;    // Wraps with the power of two size
			end
			if (store_done) begin
				ent_valid[head] <= 1'b0;
				head            <= head + 1'b1;
			end
			count <= count + {{IDX_W{1'b0}}, push} - {{IDX_W{1'b0}}, store_done};
		end
	end

	// Entry payload with operand wakeup
	always_ff @(posedge clock) begin
		for (int i = 0; i < SQ_SIZE; i++) begin
			if (push && tail == IDX_W'(i))
				ent[i] <= incoming;
			else
				ent[i] <= wakeup(ent[i], cdb);
		end
	end

endmodule

/* design/mem_issue.sv */
// Memory issue stage and tag table.
// A request stays on the bus until mem_response returns a nonzero tag.
// A flush drops any held request and forgets every outstanding load tag.

`timescale 1ns/100ps

module mem_issue import lsq_pkg::*; #(
	parameter int LQ_SIZE = 4
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       mispredict,
	input  logic                       head_ready,
	input  data_t                      head_addr,
	input  data_t                      head_data,
	input  logic                       issue_valid,
	input  logic [$clog2(LQ_SIZE)-1:0] issue_idx,
	input  data_t                      issue_addr,
	input  mem_tag_t                   mem_response,
	input  mem_tag_t                   mem_tag,
	input  data_t                      mem_data,
	output mem_req_t                   mem_req,
	output logic                       store_done,
	output logic                       issued,
	output logic [$clog2(LQ_SIZE)-1:0] issued_idx,
	output logic                       fill_valid,
	output logic [$clog2(LQ_SIZE)-1:0] fill_idx,
	output data_t                      fill_data
);

	localparam int IDX_W  = $clog2(LQ_SIZE);
	localparam int N_TAGS = 2 ** MEM_TAG_W;

	logic              hold_valid;
	mem_req_t          hold_req;
	logic [IDX_W-1:0]  hold_idx;
	logic [IDX_W-1:0]  req_idx;
	logic              accepted;

	logic [IDX_W-1:0]  tag_idx [N_TAGS];
	logic [N_TAGS-1:0] tag_valid;

	////////////////////////////////////////////////////////////
	// Request select
	////////////////////////////////////////////////////////////

	always_comb begin
		mem_req = '0;
		req_idx = issue_idx;
		if (hold_valid) begin
			mem_req = hold_req;                // Back-pressure, repeat last request
			req_idx = hold_idx;
		end else if (head_ready) begin
			mem_req.cmd  = BUS_STORE;          // Committing store goes first
			mem_req.addr = head_addr;
			mem_req.data = head_data;
		end else if (issue_valid) begin
			mem_req.cmd  = BUS_LOAD;
			mem_req.addr = issue_addr;
		end
	end

	assign accepted   = mem_req.cmd != BUS_NONE && mem_response != '0;
	assign store_done = accepted && mem_req.cmd == BUS_STORE;
	assign issued     = accepted && mem_req.cmd == BUS_LOAD;
	assign issued_idx = req_idx;

	always_ff @(posedge clock) begin
		if (reset || mispredict)
			hold_valid <= 1'b0;
		else
			hold_valid <= mem_req.cmd != BUS_NONE && mem_response == '0;
		hold_req <= mem_req;
		hold_idx <= req_idx;
	end

	////////////////////////////////////////////////////////////
	// Tag table, memory tag to load index
	////////////////////////////////////////////////////////////

	assign fill_valid = mem_tag != '0 && tag_valid[mem_tag];
	assign fill_idx   = tag_idx[mem_tag];
	assign fill_data  = mem_data;

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			tag_valid <= '0;
		end else begin
			if (fill_valid)
				tag_valid[mem_tag] <= 1'b0;
			if (issued)
				tag_valid[mem_response] <= 1'b1;   // Reuse of a tag wins over its return
		end
	end

	always_ff @(posedge clock) begin
		if (issued)
			tag_idx[mem_response] <= req_idx;
	end

endmodule

/* design/result_bus.sv */
// Result bus arbiter with a registered output.
// Load-address results always win; a filled load waits in its entry meanwhile.

`timescale 1ns/100ps

module result_bus import lsq_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  result_t lda_result,
	input  result_t load_result,
	output logic    load_grant,
	output result_t result
);

	result_t next_result;

	assign load_grant = load_result.valid && !lda_result.valid;

	always_comb begin
		if (lda_result.valid)
			next_result = lda_result;
		else if (load_grant)
			next_result = load_result;
		else
			next_result = '0;                   // Idle bus
	end

	always_ff @(posedge clock) begin
		if (reset)
			result <= '0;
		else
			result <= next_result;
	end

endmodule

/* design/lsq_top.sv */
// Load/store queue top level, single thread.
// Dispatch must stay low while lsq_full is high. Stores report no result;
// the ROB treats them as complete at dispatch. Queue sizes are powers of two.

`timescale 1ns/100ps

module lsq_top import lsq_pkg::*; #(
	parameter int LQ_SIZE = 4,
	parameter int SQ_SIZE = 4
) (
	input  logic      clock,
	input  logic      reset,
	input  dispatch_t dispatch,
	input  cdb_t      cdb,
	input  rob_idx_t  rob_head,
	input  logic      mispredict,
	input  mem_tag_t  mem_response,
	input  mem_tag_t  mem_tag,
	input  data_t     mem_data,
	output result_t   result,
	output mem_req_t  mem_req,
	output logic      lsq_full
);

	localparam int LQ_IDX_W = $clog2(LQ_SIZE);
	localparam int SQ_IDX_W = $clog2(SQ_SIZE);

	dispatch_t           dispatch_q;
	result_t             lda_result;
	result_t             load_result;
	logic                load_grant;

	logic                issue_valid;
	logic [LQ_IDX_W-1:0] issue_idx;
	data_t               issue_addr;
	logic                issued;
	logic [LQ_IDX_W-1:0] issued_idx;
	logic                fill_valid;
	logic [LQ_IDX_W-1:0] fill_idx;
	data_t               fill_data;

	logic                head_ready;
	data_t               head_addr;
	data_t               head_data;
	logic                store_done;
	logic [SQ_IDX_W:0]   sq_count;
	logic [SQ_IDX_W:0]   sq_free;
	logic [LQ_IDX_W:0]   lq_free;

	logic                lq_held;
	logic                sq_held;

	////////////////////////////////////////////////////////////
	// Full flag, counting the instruction in the dispatch register
	////////////////////////////////////////////////////////////

	assign lq_held  = dispatch_q.valid && dispatch_q.op == MEM_LOAD;
	assign sq_held  = dispatch_q.valid && dispatch_q.op == MEM_STORE;
	assign lsq_full = (int'(lq_free) - int'(lq_held) < 2)
		|| (int'(sq_free) - int'(sq_held) < 2);

	lsq_dispatch u_dispatch (
		.clock      (clock),
		.reset      (reset),
		.mispredict (mispredict),
		.dispatch   (dispatch),
		.cdb        (cdb),
		.dispatch_q (dispatch_q),
		.lda_result (lda_result)
	);

	load_queue #(
		.LQ_SIZE (LQ_SIZE),
		.SQ_SIZE (SQ_SIZE)
	) u_load_queue (
		.clock       (clock),
		.reset       (reset),
		.mispredict  (mispredict),
		.dispatch_q  (dispatch_q),
		.cdb         (cdb),
		.sq_count    (sq_count),
		.store_done  (store_done),
		.issue_valid (issue_valid),
		.issue_idx   (issue_idx),
		.issue_addr  (issue_addr),
		.issued      (issued),
		.issued_idx  (issued_idx),
		.fill_valid  (fill_valid),
		.fill_idx    (fill_idx),
		.fill_data   (fill_data),
		.load_result (load_result),
		.load_grant  (load_grant),
		.lq_free     (lq_free)
	);

	store_queue #(
		.SQ_SIZE (SQ_SIZE)
	) u_store_queue (
		.clock      (clock),
		.reset      (reset),
		.mispredict (mispredict),
		.dispatch_q (dispatch_q),
		.cdb        (cdb),
		.rob_head   (rob_head),
		.head_ready (head_ready),
		.head_addr  (head_addr),
		.head_data  (head_data),
		.store_done (store_done),
		.sq_count   (sq_count),
		.sq_free    (sq_free)
	);

	mem_issue #(
		.LQ_SIZE (LQ_SIZE)
	) u_mem_issue (
		.clock        (clock),
		.reset        (reset),
		.mispredict   (mispredict),
		.head_ready   (head_ready),
		.head_addr    (head_addr),
		.head_data    (head_data),
		.issue_valid  (issue_valid),
		.issue_idx    (issue_idx),
		.issue_addr   (issue_addr),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.mem_data     (mem_data),
		.mem_req      (mem_req),
		.store_done   (store_done),
		.issued       (issued),
		.issued_idx   (issued_idx),
		.fill_valid   (fill_valid),
		.fill_idx     (fill_idx),
		.fill_data    (fill_data)
	);

	result_bus u_result_bus (
		.clock       (clock),
		.reset       (reset),
		.lda_result  (lda_result),
		.load_result (load_result),
		.load_grant  (load_grant),
		.result      (result)
	);

endmodule

/* sim/lsq_sva.sv */
// Protocol assertions bound into the load/store queue top level.
// Covers idle outputs after reset, request hold under back-pressure
// and the rule that dispatch stays low while the queues are full.

`timescale 1ns/100ps

module lsq_sva import lsq_pkg::*; (
	input logic      clock,
	input logic      reset,
	input logic      mispredict,
	input dispatch_t dispatch,
	input mem_tag_t  mem_response,
	input mem_req_t  mem_req,
	input result_t   result,
	input logic      lsq_full
);

	// Outputs come out of reset idle
	reset_idle: assert property (@(posedge clock)
		$fell(reset) |-> !result.valid && !lsq_full)
		else $error("result.valid or lsq_full high in the cycle after reset");

	// A refused request is repeated unchanged, a flush may drop it
	request_held: assert property (@(posedge clock) disable iff (reset)
		mem_req.cmd != BUS_NONE && mem_response == '0 && !mispredict |=> $stable(mem_req))
		else $error("memory request changed while it was not accepted");

	no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
		!(dispatch.valid && lsq_full))
		else $error("instruction dispatched while lsq_full was high");

endmodule

bind lsq_top lsq_sva u_lsq_sva (.*);

/* sim/lsq_tb.sv */
// Directed testbench for the load/store queue with a tagged memory model.
// An unwritten address reads as the address XOR 64'h5a5a.
// Load data returns 2 to 6 cycles after acceptance, tags rotate 1 to 15.
// Test tasks start on a rising edge and sample outputs 1 ns after an edge.

`timescale 1ns/100ps

module lsq_tb import lsq_pkg::*; ();

	localparam int          LQ_SIZE = 4;
	localparam int          SQ_SIZE = 4;
	localparam int          TIMEOUT = 50;
	localparam logic [31:0] SEED    = 32'h02db_8005;

	logic      clock;
	logic      reset;
	dispatch_t dispatch;
	cdb_t      cdb;
	rob_idx_t  rob_head;
	logic      mispredict;
	mem_tag_t  mem_response;
	mem_tag_t  mem_tag;
	data_t     mem_data;
	result_t   result;
	mem_req_t  mem_req;
	logic      lsq_full;

	data_t     mem [data_t];          // Byte-addressed words
	mem_tag_t  tag_ctr;
	logic      backpressure;
	mem_tag_t  pend_tag [$];
	data_t     pend_data [$];
	int        pend_due [$];
	int        cycle;
	int        resp_count;
	int        errors;
	int        tests_run;

	lsq_top #(
		.LQ_SIZE (LQ_SIZE),
		.SQ_SIZE (SQ_SIZE)
	) u_lsq_top (
		.clock        (clock),
		.reset        (reset),
		.dispatch     (dispatch),
		.cdb          (cdb),
		.rob_head     (rob_head),
		.mispredict   (mispredict),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.mem_data     (mem_data),
		.result       (result),
		.mem_req      (mem_req),
		.lsq_full     (lsq_full)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// Memory model
	////////////////////////////////////////////////////////////

	assign mem_response = backpressure ? '0 : tag_ctr;   // Next tag offered every cycle

	function automatic data_t read_mem(input data_t addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr ^ 64'h5a5a;
	endfunction

	initial begin : memory_model
		int delay;
		int i;
		logic found;
		tag_ctr    = 4'd1;
		mem_tag    = '0;
		mem_data   = '0;
		cycle      = 0;
		resp_count = 0;
		void'($urandom(SEED));
		forever begin
			@(posedge clock);
			cycle++;
			// At most one load response per cycle
			found = 1'b0;
			mem_tag <= '0;
			for (i = 0; i < pend_tag.size() && !found; i++) begin
				if (pend_due[i] <= cycle) begin
					mem_tag  <= pend_tag[i];
					mem_data <= pend_data[i];
					pend_tag.delete(i);
					pend_data.delete(i);
					pend_due.delete(i);
					resp_count++;
					found = 1'b1;
				end
			end
			if (!reset && mem_req.cmd != BUS_NONE && mem_response != '0) begin
				if (mem_req.cmd == BUS_STORE) begin
					mem[mem_req.addr] = mem_req.data;
				end else begin
					delay = 2 + $urandom % 5;
					pend_tag.push_back(mem_response);
					pend_data.push_back(read_mem(mem_req.addr));
					pend_due.push_back(cycle + delay);
				end
				tag_ctr <= (tag_ctr == 4'd15) ? 4'd1 : tag_ctr + 4'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t: %s", $time, what);
		errors++;
	endtask

	function automatic dispatch_t make_inst(input mem_op_e op, input data_t opa,
		input data_t opb, input logic opb_ready, input data_t rega, input logic rega_ready,
		input rob_idx_t rob_idx, input prf_tag_t dest_tag);
		dispatch_t d;
		d.valid      = 1'b1;
		d.op         = op;
		d.opa        = opa;
		d.opb        = opb;
		d.opb_ready  = opb_ready;
		d.rega       = rega;
		d.rega_ready = rega_ready;
		d.rob_idx    = rob_idx;
		d.dest_tag   = dest_tag;
		return d;
	endfunction

	// Present for one cycle, returns on the capture edge
	task automatic send_inst(input dispatch_t d);
		dispatch <= d;
		@(posedge clock);
		dispatch <= '0;
	endtask

	task automatic wait_request(input bus_cmd_e cmd, output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		#1;
		while (!seen && n < TIMEOUT) begin
			if (mem_req.cmd == cmd) begin
				seen = 1'b1;
			end else begin
				if (mem_req.cmd != BUS_NONE)
					report_mismatch("mem_req.cmd", cmd, mem_req.cmd);
				@(posedge clock);
				#1;
				n++;
			end
		end
		if (!seen)
			report_failure("timed out waiting for a memory request");
	endtask

	task automatic wait_result(output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		#1;
		while (!result.valid && n < TIMEOUT) begin
			@(posedge clock);
			#1;
			n++;
		end
		seen = result.valid;
		if (!seen)
			report_failure("timed out waiting for a result");
	endtask

	task automatic expect_no_request(input int cycles);
		for (int n = 0; n < cycles; n++) begin
			#1;
			if (mem_req.cmd !== BUS_NONE)
				report_mismatch("mem_req.cmd", BUS_NONE, mem_req.cmd);
			@(posedge clock);
		end
	endtask

	task automatic check_result(input prf_tag_t dest_tag, input rob_idx_t rob_idx,
		input data_t data);
		if (result.dest_tag !== dest_tag)
			report_mismatch("result.dest_tag", dest_tag, result.dest_tag);
		if (result.rob_idx !== rob_idx)
			report_mismatch("result.rob_idx", rob_idx, result.rob_idx);
		if (result.data !== data)
			report_mismatch("result.data", data, result.data);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic load_address_result();
		tests_run++;
		send_inst(make_inst(MEM_LDA, 64'h1000, 64'h24, 1'b1, '0, 1'b1, 5'd3, 6'd12));
		#1;
		if (result.valid !== 1'b1)
			report_mismatch("result.valid", 1, result.valid);
		check_result(6'd12, 5'd3, 64'h1024);
		@(posedge clock);
		#1;
		if (result.valid !== 1'b0)      // Exactly one cycle
			report_mismatch("result.valid", 0, result.valid);
		@(posedge clock);
	endtask

	task automatic backpressured_load();
		logic seen;
		tests_run++;
		backpressure <= 1'b1;
		send_inst(make_inst(MEM_LOAD, 64'h2000, 64'h8, 1'b1, '0, 1'b1, 5'd4, 6'd20));
		wait_request(BUS_LOAD, seen);
		if (seen && mem_req.addr !== 64'h2008)
			report_mismatch("mem_req.addr", 64'h2008, mem_req.addr);
		repeat (4) begin
			@(posedge clock);
			#1;
			if (mem_req.cmd !== BUS_LOAD)
				report_mismatch("mem_req.cmd", BUS_LOAD, mem_req.cmd);
			if (mem_req.addr !== 64'h2008)
				report_mismatch("mem_req.addr", 64'h2008, mem_req.addr);
		end
		@(posedge clock);
		backpressure <= 1'b0;
		wait_result(seen);
		if (seen)
			check_result(6'd20, 5'd4, 64'h2008 ^ 64'h5a5a);
		@(posedge clock);
	endtask

	task automatic late_offset_wakeup();
		logic seen;
		tests_run++;
		// Offset waits on physical register 9
		send_inst(make_inst(MEM_LOAD, 64'h3000, 64'd9, 1'b0, '0, 1'b1, 5'd5, 6'd21));
		expect_no_request(5);
		cdb <= '{valid: 1'b1, tag: 6'd9, data: 64'h40};
		@(posedge clock);
		cdb <= '0;
		wait_request(BUS_LOAD, seen);
		if (seen && mem_req.addr !== 64'h3040)
			report_mismatch("mem_req.addr", 64'h3040, mem_req.addr);
		@(posedge clock);
		wait_result(seen);
		if (seen)
			check_result(6'd21, 5'd5, 64'h3040 ^ 64'h5a5a);
		@(posedge clock);
	endtask

	task automatic store_before_load();
		logic  seen;
		data_t value;
		tests_run++;
		value = 64'hdead_beef_0123_4567;
		send_inst(make_inst(MEM_STORE, 64'h4000, 64'h10, 1'b1, value, 1'b1, 5'd7, 6'd0));
		send_inst(make_inst(MEM_LOAD, 64'h4000, 64'h10, 1'b1, '0, 1'b1, 5'd8, 6'd22));
		expect_no_request(6);               // ROB head not yet at the store
		rob_head <= 5'd7;
		wait_request(BUS_STORE, seen);
		if (seen && mem_req.addr !== 64'h4010)
			report_mismatch("mem_req.addr", 64'h4010, mem_req.addr);
		if (seen && mem_req.data !== value)
			report_mismatch("mem_req.data", value, mem_req.data);
		@(posedge clock);
		wait_request(BUS_LOAD, seen);
		if (seen && mem_req.addr !== 64'h4010)
			report_mismatch("mem_req.addr", 64'h4010, mem_req.addr);
		@(posedge clock);
		wait_result(seen);
		if (seen)
			check_result(6'd22, 5'd8, value);
		@(posedge clock);
	endtask

	task automatic flush_held_loads();
		logic seen;
		int   n;
		int   resp_before;
		tests_run++;
		backpressure <= 1'b1;
		send_inst(make_inst(MEM_LOAD, 64'h5000, 64'h0, 1'b1, '0, 1'b1, 5'd9, 6'd30));
		send_inst(make_inst(MEM_LOAD, 64'h5100, 64'h0, 1'b1, '0, 1'b1, 5'd10, 6'd31));
		send_inst(make_inst(MEM_LOAD, 64'h5200, 64'h0, 1'b1, '0, 1'b1, 5'd11, 6'd32));
		n = 0;
		#1;
		while (!lsq_full && n < TIMEOUT) begin
			@(posedge clock);
			#1;
			n++;
		end
		if (!lsq_full)
			report_failure("lsq_full did not rise with three loads held");
		if (mem_req.cmd !== BUS_LOAD)
			report_mismatch("mem_req.cmd", BUS_LOAD, mem_req.cmd);
		resp_before = resp_count;
		@(posedge clock);
		mispredict   <= 1'b1;
		backpressure <= 1'b0;               // Held load accepted on the flush edge
		@(posedge clock);
		mispredict   <= 1'b0;
		backpressure <= 1'b1;
		// A new load takes the flushed load's entry before the stale data returns
		send_inst(make_inst(MEM_LOAD, 64'h5300, 64'h0, 1'b1, '0, 1'b1, 5'd12, 6'd33));
		#1;
		if (lsq_full !== 1'b0)
			report_mismatch("lsq_full", 0, lsq_full);
		for (n = 0; n < 15; n++) begin
			@(posedge clock);
			#1;
			if (result.valid !== 1'b0)
				report_mismatch("result.valid", 0, result.valid);
		end
		if (resp_count == resp_before)
			report_failure("memory never responded to the flushed load");
		@(posedge clock);
		backpressure <= 1'b0;
		wait_result(seen);
		if (seen)
			check_result(6'd33, 5'd12, 64'h5300 ^ 64'h5a5a);
		@(posedge clock);
	endtask

	initial begin
		reset        = 1'b1;
		dispatch     = '0;
		cdb          = '0;
		rob_head     = '0;
		mispredict   = 1'b0;
		backpressure = 1'b0;
		errors       = 0;
		tests_run    = 0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		load_address_result();
		backpressured_load();
		late_offset_wakeup();
		store_before_load();
		flush_held_loads();
		repeat (2) @(posedge clock);
		$display("Tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* all.f */
design/lsq_pkg.sv
design/lsq_dispatch.sv
design/load_queue.sv
design/store_queue.sv
design/mem_issue.sv
design/result_bus.sv
design/lsq_top.sv
sim/lsq_sva.sv
sim/lsq_tb.sv
